//--- cpu_types_pkg.sv
// shared word and address types plus instruction-address field widths
`default_nettype none

package cpu_types_pkg;

  // machine word width
  localparam int WORD_W = 32;

  // byte address width
  localparam int ADDR_W = 32;

  // instruction address layout, msb to lsb
  //   [ tag | index | block offset | byte offset ]
  // tag and index widths depend on cache size
  // so they are worked out inside the cache

  // byte offset inside a word
  // four bytes per word, fetch always word aligned
  localparam int IBYT_W = 2;

  // word offset inside a block
  // one-word blocks, so the field is empty
  localparam int IBLK_W = 0;

  // everything below the index field
  localparam int IOFF_W = IBLK_W + IBYT_W;

  // one instruction or data word
  typedef logic [WORD_W-1:0] word_t;

  // one byte address
  typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

//--- ifetch_ctrl_pkg.sv
// control encodings for the refill controller and the fetch stage
`default_nettype none

package ifetch_ctrl_pkg;

  // refill controller states
  // idle looks up, request waits on memory, load writes the frame
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    REQUEST = 2'd1,
    LOAD    = 2'd2
  } icache_state_e;

  // per-cycle fetch stage action
  typedef enum logic [1:0] {
    FETCH_HOLD     = 2'd0,
    FETCH_NEXT     = 2'd1,
    FETCH_REDIRECT = 2'd2
  } fetch_op_e;

endpackage

`default_nettype wire

//--- datapath_cache_if.sv
// fetch stage to instruction cache signals
`timescale 1ns/1ps
`default_nettype none

interface datapath_cache_if;
  import cpu_types_pkg::*;

  // fetch request, level while the pc is valid
  logic  imemREN;
  addr_t imemaddr;

  // cache answer, combinational from the address
  logic  ihit;
  word_t imemload;

  // fetch stage side
  modport datapath (
    output imemREN, imemaddr,
    input  ihit, imemload
  );

  // cache side
  modport cache (
    input  imemREN, imemaddr,
    output ihit, imemload
  );

endinterface

`default_nettype wire

//--- caches_if.sv
// instruction cache to memory refill signals
`timescale 1ns/1ps
`default_nettype none

interface caches_if;
  import cpu_types_pkg::*;

  // read level, address held steady while high
  logic  iREN;
  addr_t iaddr;

  // memory reply, word good in the cycle iwait drops
  word_t iload;
  logic  iwait;

  // cache side
  modport cache (
    output iREN, iaddr,
    input  iload, iwait
  );

  // memory side
  modport mem (
    input  iREN, iaddr,
    output iload, iwait
  );

endinterface

`default_nettype wire

//--- icache.sv
// direct-mapped instruction cache with one-word frames and a refill controller
`timescale 1ns/1ps
`default_nettype none

module icache #(
  parameter int unsigned NUM_BLOCKS = 16
) (
  input  logic            CLK,
  input  logic            nRST,
  datapath_cache_if.cache dcif,
  caches_if.cache         cif
);
  import cpu_types_pkg::*;
  import ifetch_ctrl_pkg::*;

  // index and tag widths follow from the block count
  localparam int IDX_W = $clog2(NUM_BLOCKS);
  localparam int TAG_W = ADDR_W - IDX_W - IOFF_W;

  // one cache line
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    word_t            data;
  } frame_t;

  // frame storage
  frame_t frames [NUM_BLOCKS];

  // lookup side fields
  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  frame_t           rd_frame;
  logic             tag_match;

  // refill side
  icache_state_e    state_q;
  icache_state_e    state_d;
  addr_t            miss_addr_q;
  word_t            fill_q;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic             latch_miss;
  logic             capture;
  logic             wen;

  // split the fetch address, byte offset ignored
  assign rd_idx = dcif.imemaddr[IOFF_W +: IDX_W];
  assign rd_tag = dcif.imemaddr[ADDR_W-1 -: TAG_W];

  // same split for the address under refill
  assign fill_idx = miss_addr_q[IOFF_W +: IDX_W];
  assign fill_tag = miss_addr_q[ADDR_W-1 -: TAG_W];

  // frame read and compare
  assign rd_frame  = frames[rd_idx];
  assign tag_match = rd_frame.valid && (rd_frame.tag == rd_tag);

  // hit only counts while a fetch is asked for
  assign dcif.ihit     = dcif.imemREN && tag_match;
  assign dcif.imemload = rd_frame.data;

  // new miss only starts from idle
  assign latch_miss = (state_q == IDLE) && dcif.imemREN && !tag_match;

  // word arrives the cycle wait drops
  assign capture = (state_q == REQUEST) && !cif.iwait;

  // frame write happens in load
  assign wen = (state_q == LOAD);

  // memory side, latched address stays put for the whole request
  assign cif.iREN  = (state_q == REQUEST);
  assign cif.iaddr = miss_addr_q;

  // controller next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (latch_miss) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        // stay while memory holds wait
        if (capture) begin
          state_d = LOAD;
        end
      end
      LOAD: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // controller state
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // miss address and fill word
  always_ff @(posedge CLK) begin
    if (latch_miss) begin
      miss_addr_q <= dcif.imemaddr;
    end
    if (capture) begin
      fill_q <= cif.iload;
    end
  end

  // frames, all invalid after reset
  // a conflicting tag is simply overwritten
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < NUM_BLOCKS; i++) begin
        frames[i] <= '0;
      end
    end else if (wen) begin
      frames[fill_idx].valid <= 1'b1;
      frames[fill_idx].tag   <= fill_tag;
      frames[fill_idx].data  <= fill_q;
    end
  end

endmodule

`default_nettype wire

//--- fetch_unit.sv
// fetch stage with program counter, redirect and stall control and the decode latch
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter cpu_types_pkg::addr_t RESET_PC = '0
) (
  input  logic                  CLK,
  input  logic                  nRST,
  datapath_cache_if.datapath    dcif,
  input  logic                  stall,
  input  logic                  redirect,
  input  cpu_types_pkg::addr_t  redirect_pc,
  output cpu_types_pkg::word_t  instr,
  output cpu_types_pkg::addr_t  instr_pc,
  output logic                  instr_valid
);
  import cpu_types_pkg::*;
  import ifetch_ctrl_pkg::*;

  // one word per fetch
  localparam addr_t PC_STEP = addr_t'(1) << IBYT_W;

  addr_t     pc_q;
  logic      ren_q;
  fetch_op_e op;

  // fetch/decode latch
  word_t instr_q;
  addr_t instr_pc_q;
  logic  valid_q;

  // fetch request rises the cycle after reset lets go
  assign dcif.imemREN  = ren_q;
  assign dcif.imemaddr = pc_q;

  // redirect first, then a hit that decode can take
  always_comb begin
    if (redirect) begin
      op = FETCH_REDIRECT;
    end else if (dcif.ihit && !stall) begin
      op = FETCH_NEXT;
    end else begin
      op = FETCH_HOLD;
    end
  end

  // fetch enable
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ren_q <= 1'b0;
    end else begin
      ren_q <= 1'b1;
    end
  end

  // pc and latch valid bit
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end else begin
      case (op)
        FETCH_REDIRECT: begin
          // flush whatever sits in the latch
          pc_q    <= redirect_pc;
          valid_q <= 1'b0;
        end
        FETCH_NEXT: begin
          pc_q    <= pc_q + PC_STEP;
          valid_q <= 1'b1;
        end
        default: begin
          // pc holds, stall keeps the latch as is
          if (!stall) begin
            valid_q <= 1'b0;
          end
        end
      endcase
    end
  end

  // latch payload, only loads on a taken hit
  always_ff @(posedge CLK) begin
    if (op == FETCH_NEXT) begin
      instr_q    <= dcif.imemload;
      instr_pc_q <= pc_q;
    end
  end

  assign instr       = instr_q;
  assign instr_pc    = instr_pc_q;
  assign instr_valid = valid_q;

endmodule

`default_nettype wire

//--- ifetch_top.sv
// instruction fetch subsystem top with fetch stage, cache and memory ports
`timescale 1ns/1ps
`default_nettype none

module ifetch_top #(
  parameter int unsigned          NUM_BLOCKS = 16,
  parameter cpu_types_pkg::addr_t RESET_PC   = '0
) (
  input  logic                  CLK,
  input  logic                  nRST,

  // decode side
  input  logic                  stall,
  input  logic                  redirect,
  input  cpu_types_pkg::addr_t  redirect_pc,
  output cpu_types_pkg::word_t  instr,
  output cpu_types_pkg::addr_t  instr_pc,
  output logic                  instr_valid,

  // memory side, level protocol
  output logic                  mem_ren,
  output cpu_types_pkg::addr_t  mem_addr,
  input  cpu_types_pkg::word_t  mem_rdata,
  input  logic                  mem_wait
);

  // stage links
  datapath_cache_if dcif ();
  caches_if         cif ();

  // program counter and decode latch
  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch_unit (
    .CLK         (CLK),
    .nRST        (nRST),
    .dcif        (dcif.datapath),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .instr       (instr),
    .instr_pc    (instr_pc),
    .instr_valid (instr_valid)
  );

  // cache and refill
  icache #(
    .NUM_BLOCKS (NUM_BLOCKS)
  ) u_icache (
    .CLK  (CLK),
    .nRST (nRST),
    .dcif (dcif.cache),
    .cif  (cif.cache)
  );

  // memory interface out to plain ports
  assign mem_ren   = cif.iREN;
  assign mem_addr  = cif.iaddr;
  assign cif.iload = mem_rdata;
  assign cif.iwait = mem_wait;

endmodule

`default_nettype wire

//--- tb_imem.sv
// testbench instruction memory with random wait levels and a read counter
`timescale 1ns/1ps
`default_nettype none

module tb_imem #(
  parameter logic [31:0] SEED = 32'h4594
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 mem_ren,
  input  cpu_types_pkg::addr_t mem_addr,
  output cpu_types_pkg::word_t mem_rdata,
  output logic                 mem_wait,
  output int unsigned          reads
);
  import cpu_types_pkg::*;

  // current draw, low two bits give the wait length
  logic [31:0] rnd_q;
  logic [1:0]  waited_q;

  // xorshift32 step
  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // wait stays high until the drawn count has passed, 0 means same cycle
  assign mem_wait  = mem_ren && (waited_q < rnd_q[1:0]);
  // word = address xor marker plus word index
  assign mem_rdata = (mem_addr ^ 32'hC0DE0000) + (mem_addr >> IBYT_W);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      rnd_q    <= next_rand(SEED);
      waited_q <= '0;
      reads    <= 0;
    end else if (mem_ren) begin
      if (mem_wait) begin
        waited_q <= waited_q + 2'd1;
      end else begin
        // read delivered, draw the next wait length
        waited_q <= '0;
        rnd_q    <= next_rand(rnd_q);
        reads    <= reads + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_ifetch.sv
// testbench top that runs fetch, hit, refill, conflict, stall and redirect tests on the fetch subsystem
`timescale 1ns/1ps
`default_nettype none

module tb_ifetch;
  import cpu_types_pkg::*;

  // 32 frames so the word after a 16-word run does not evict the run
  localparam int unsigned NUM_BLOCKS  = 32;
  localparam addr_t       RESET_PC    = 32'h0000_0100;
  localparam addr_t       WORD_STEP   = addr_t'(1) << IBYT_W;
  localparam addr_t       CONFLICT_PC = RESET_PC + (NUM_BLOCKS << (IBYT_W + IBLK_W));
  localparam addr_t       MISS_PC     = RESET_PC + 32'h400;
  localparam addr_t       TARGET_PC   = RESET_PC + 32'h244;
  // 16 cold, 16 warm, 2 conflict, 5 stall, 2 redirect
  localparam int          TOTAL_FETCHES = 41;
  localparam int          CYCLE_LIMIT   = 8 * TOTAL_FETCHES * 6;

  logic        CLK = 1'b0;
  logic        nRST, stall, redirect;
  addr_t       redirect_pc, instr_pc, mem_addr;
  word_t       instr, mem_rdata, held_instr;
  addr_t       held_pc, exp_pc;
  logic        instr_valid, mem_ren, mem_wait, held_valid, seen;
  int unsigned reads, r0;
  int          errors = 0, err_mark = 0, tests_run = 0, tests_failed = 0, cycles = 0;

  ifetch_top #(.NUM_BLOCKS(NUM_BLOCKS), .RESET_PC(RESET_PC)) u_ifetch_top (
    .CLK(CLK), .nRST(nRST), .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
    .instr(instr), .instr_pc(instr_pc), .instr_valid(instr_valid),
    .mem_ren(mem_ren), .mem_addr(mem_addr), .mem_rdata(mem_rdata), .mem_wait(mem_wait)
  );

  tb_imem #(.SEED(32'h4594)) u_tb_imem (
    .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_addr(mem_addr),
    .mem_rdata(mem_rdata), .mem_wait(mem_wait), .reads(reads)
  );

  always #50 CLK = ~CLK;

  // expected memory word
  function automatic word_t expect_word(input addr_t a);
    return (a ^ 32'hC0DE0000) + (a >> IBYT_W);
  endfunction

  task automatic flag_error(input string msg);
    errors = errors + 1;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    tests_run = tests_run + 1;
    if (errors != err_mark) begin
      tests_failed = tests_failed + 1;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end else begin
      $display("test %s: ok", name);
    end
    err_mark = errors;
  endtask

  // decode takes an instruction when valid and not stalling
  task automatic take_instrs(input int n, input logic expect_quiet);
    int got;
    got = 0;
    while (got < n) begin
      @(negedge CLK);
      if (expect_quiet) begin
        assert (!mem_ren) else flag_error("memory read during warm fetch");
      end
      if (instr_valid && !stall) begin
        assert (instr_pc == exp_pc)
          else flag_error($sformatf("instr_pc %h, expected %h", instr_pc, exp_pc));
        assert (instr == expect_word(exp_pc))
          else flag_error($sformatf("instr %h, expected %h", instr, expect_word(exp_pc)));
        exp_pc = exp_pc + WORD_STEP;
        got = got + 1;
      end
    end
  endtask

  task automatic pulse_redirect(input addr_t pc);
    @(posedge CLK);
    redirect    <= 1'b1;
    redirect_pc <= pc;
    @(posedge CLK);
    redirect    <= 1'b0;
  endtask

  // redirect with stall held, then wait for any refill to drain
  task automatic park(input addr_t pc);
    int quiet;
    @(posedge CLK);
    stall <= 1'b1;
    pulse_redirect(pc);
    quiet = 0;
    while (quiet < 3) begin
      @(negedge CLK);
      quiet = mem_ren ? 0 : quiet + 1;
    end
  endtask

  task automatic release_stall();
    @(posedge CLK);
    stall <= 1'b0;
  endtask

  a_reset_quiet: assert property (@(negedge CLK) !nRST |-> (!mem_ren && !instr_valid))
    else flag_error("fetch or memory read active during reset");
  a_instr_word: assert property (@(posedge CLK) disable iff (!nRST)
    instr_valid |-> (instr == expect_word(instr_pc)))
    else flag_error("instr does not match memory word for instr_pc");
  a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (stall && !redirect) |=> ($stable(instr) && $stable(instr_pc) && $stable(instr_valid)))
    else flag_error("decode latch changed under stall");
  a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_ren && mem_wait) |=> (mem_ren && $stable(mem_addr)))
    else flag_error("read address moved during wait");

  // watchdog
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    nRST = 1'b0;
    stall = 1'b0;
    redirect = 1'b0;
    redirect_pc = '0;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    repeat (2) begin
      @(negedge CLK);
      assert (!instr_valid && !mem_ren) else flag_error("output active right after reset");
    end
    end_test("reset");

    // cold run, one read per word, first pc is the reset pc
    exp_pc = RESET_PC;
    r0 = reads;
    take_instrs(16, 1'b0);
    assert (reads - r0 == 16) else flag_error($sformatf("%0d reads, expected 16", reads - r0));
    end_test("cold sequential fetch");

    park(RESET_PC);
    r0 = reads;
    release_stall();
    exp_pc = RESET_PC;
    take_instrs(16, 1'b1);
    assert (reads == r0) else flag_error("read count rose during warm fetch");
    end_test("warm hits");

    park(RESET_PC);
    r0 = reads;
    park(CONFLICT_PC);
    assert (reads == r0 + 1) else flag_error("conflict address was not read from memory");
    release_stall();
    exp_pc = CONFLICT_PC;
    take_instrs(1, 1'b0);
    park(CONFLICT_PC);
    r0 = reads;
    park(RESET_PC);
    assert (reads == r0 + 1) else flag_error("replaced frame was not read again");
    release_stall();
    exp_pc = RESET_PC;
    take_instrs(1, 1'b0);
    end_test("tag conflict");

    take_instrs(2, 1'b0);
    @(posedge CLK);
    stall <= 1'b1;
    @(negedge CLK);
    held_instr = instr;
    held_pc    = instr_pc;
    held_valid = instr_valid;
    repeat (4) begin
      @(negedge CLK);
      assert (instr === held_instr && instr_pc === held_pc && instr_valid === held_valid)
        else flag_error("decode latch moved while stalled");
    end
    release_stall();
    take_instrs(3, 1'b0);
    end_test("stall");

    // second redirect lands while the first target is still refilling
    pulse_redirect(MISS_PC);
    seen = 1'b0;
    while (!seen) begin
      @(negedge CLK);
      seen = mem_ren && (mem_addr == MISS_PC);
    end
    pulse_redirect(TARGET_PC);
    exp_pc = TARGET_PC;
    take_instrs(2, 1'b0);
    end_test("redirect during miss");

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
cpu_types_pkg.sv
ifetch_ctrl_pkg.sv
datapath_cache_if.sv
caches_if.sv
icache.sv
fetch_unit.sv
ifetch_top.sv
tb_imem.sv
tb_ifetch.sv

//--- Bender.yml
package:
  name: ifetch

sources:
  - cpu_types_pkg.sv
  - ifetch_ctrl_pkg.sv
  - datapath_cache_if.sv
  - caches_if.sv
  - icache.sv
  - fetch_unit.sv
  - ifetch_top.sv
  - target: test
    files:
      - tb_imem.sv
      - tb_ifetch.sv
